/* source/csr_pkg.sv */
package csr_pkg;

    localparam int xlen           = 32;
    localparam int csr_addr_width = 12;
    localparam int reg_addr_width = 5;
    localparam int uimm_width     = 5;

    // RV32I major opcodes, bits 1:0 always 11.
    typedef enum logic [6:0] {
        opcode_load     = 7'b00_000_11,
        opcode_misc_mem = 7'b00_011_11,
        opcode_op_imm   = 7'b00_100_11,
        opcode_auipc    = 7'b00_101_11,
        opcode_store    = 7'b01_000_11,
        opcode_op       = 7'b01_100_11,
        opcode_lui      = 7'b01_101_11,
        opcode_branch   = 7'b11_000_11,
        opcode_jalr     = 7'b11_001_11,
        opcode_jal      = 7'b11_011_11,
        opcode_system   = 7'b11_100_11
    } opcode_e;

    // zicsr operations, value is the funct3 code.
    typedef enum logic [2:0] {
        csrrw  = 3'b001,
        csrrs  = 3'b010,
        csrrc  = 3'b011,
        csrrwi = 3'b101,
        csrrsi = 3'b110,
        csrrci = 3'b111
    } csr_funct3_e;

    localparam logic [2:0] funct3_priv     = 3'b000; // ecall, ebreak, mret.
    localparam logic [2:0] funct3_reserved = 3'b100;

    typedef enum logic [11:0] {
        csr_mstatus  = 12'h300,
        csr_misa     = 12'h301,
        csr_mie      = 12'h304,
        csr_mtvec    = 12'h305,
        csr_mscratch = 12'h340,
        csr_mepc     = 12'h341,
        csr_mcause   = 12'h342,
        csr_mtval    = 12'h343,
        csr_mcycle   = 12'hB00,
        csr_minstret = 12'hB02,
        csr_cycle    = 12'hC00,
        csr_instret  = 12'hC02,
        csr_mhartid  = 12'hF14
    } csr_addr_e;

    localparam logic [xlen-1:0] mstatus_mask = 32'h0000_0088; // mie, mpie.
    localparam logic [xlen-1:0] mie_mask     = 32'h0000_0888; // msie, mtie, meie.
    localparam logic [xlen-1:0] mtvec_mask   = 32'hFFFF_FFFD;
    localparam logic [xlen-1:0] mepc_mask    = 32'hFFFF_FFFC;
    localparam logic [xlen-1:0] full_mask    = 32'hFFFF_FFFF;
    localparam logic [xlen-1:0] misa_value   = 32'h4000_0100; // mxl=1, I only.
    localparam logic [xlen-1:0] hartid_value = 32'h0000_0000;

    typedef struct packed {
        logic                          valid;
        csr_funct3_e                   op;
        logic [csr_addr_width-1:0]     addr;
        logic [xlen-1:0]               operand;
        logic                          src_zero;
        logic [reg_addr_width-1:0]     rd_addr;
        logic                          bad_encoding;
    } csr_req_t;

    typedef struct packed {
        logic            valid;
        logic [31:0]     instr;
        logic [xlen-1:0] rs1_data;
    } csr_issue_t;

    typedef struct packed {
        logic                      done;
        logic                      illegal;
        logic                      rd_write;
        logic [reg_addr_width-1:0] rd_addr;
        logic [xlen-1:0]           rd_data;
    } csr_result_t;

endpackage

/* source/csr_decoder.sv */
`timescale 1ns/1ps

module csr_decoder (
    input  csr_pkg::csr_issue_t issue,
    output csr_pkg::csr_req_t   req
);
    import csr_pkg::*;

    opcode_e                   opcode;
    logic [2:0]                funct3;
    logic [reg_addr_width-1:0] rd_field;
    logic [uimm_width-1:0]     rs1_field;
    logic [csr_addr_width-1:0] csr_addr;
    logic                      not_system;
    logic                      not_zicsr;
    logic                      imm_form;
    logic [xlen-1:0]           uimm_ext;

    // I-type layout.
    assign opcode    = opcode_e'(issue.instr[6:0]);
    assign rd_field  = issue.instr[11:7];
    assign funct3    = issue.instr[14:12];
    assign rs1_field = issue.instr[19:15];
    assign csr_addr  = issue.instr[31:20];

    assign not_system = (opcode != opcode_system);
    assign not_zicsr  = (funct3 == funct3_priv) || (funct3 == funct3_reserved);

    assign imm_form = funct3[2]; // uimm variants.
    assign uimm_ext = {{(xlen - uimm_width){1'b0}}, rs1_field};

    always_comb begin
        req              = '0;
        req.valid        = issue.valid;
        req.op           = csr_funct3_e'(funct3);
        req.addr         = csr_addr;
        req.operand      = imm_form ? uimm_ext : issue.rs1_data;
        req.src_zero     = (rs1_field == '0); // x0 or uimm 0.
        req.rd_addr      = rd_field;
        req.bad_encoding = not_system || not_zicsr;
    end

endmodule

/* source/csr_alu.sv */
`timescale 1ns/1ps

module csr_alu (
    input  csr_pkg::csr_funct3_e          op,
    input  logic [csr_pkg::xlen-1:0]      operand,
    input  logic                          src_zero,
    input  logic [csr_pkg::xlen-1:0]      old_value,
    output logic [csr_pkg::xlen-1:0]      new_value,
    output logic                          write_req
);
    import csr_pkg::*;

    logic [xlen-1:0] set_value;
    logic [xlen-1:0] clear_value;

    assign set_value   = old_value | operand;
    assign clear_value = old_value & ~operand;

    // immediate forms already folded into operand.
    always_comb begin
        case (op)
            csrrw, csrrwi: begin
                new_value = operand;
                write_req = 1'b1;
            end
            csrrs, csrrsi: begin
                new_value = set_value;
                write_req = !src_zero; // x0 source never writes.
            end
            csrrc, csrrci: begin
                new_value = clear_value;
                write_req = !src_zero;
            end
            default: begin
                new_value = old_value;
                write_req = 1'b0;
            end
        endcase
    end

endmodule

/* source/csr_file.sv */
`timescale 1ns/1ps

module csr_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [csr_pkg::csr_addr_width-1:0]  addr,
    input  logic                                write_req,
    input  logic                                commit,
    input  logic [csr_pkg::xlen-1:0]            new_value,
    input  logic                                retire,
    output logic [csr_pkg::xlen-1:0]            old_value,
    output logic                                addr_ok
);
    import csr_pkg::*;

    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mie;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mtval;
    logic [xlen-1:0] mcycle;
    logic [xlen-1:0] minstret;

    logic            implemented;
    logic            read_only;
    logic [xlen-1:0] write_mask;
    logic [xlen-1:0] masked_value;
    logic            write_mcycle;
    logic            write_minstret;

    // read mux and per-address mask.
    always_comb begin
        implemented = 1'b1;
        old_value   = '0;
        write_mask  = '0;
        case (csr_addr_e'(addr))
            csr_mstatus: begin
                old_value  = mstatus;
                write_mask = mstatus_mask;
            end
            csr_misa:     old_value = misa_value; // WARL, writes dropped.
            csr_mie: begin
                old_value  = mie;
                write_mask = mie_mask;
            end
            csr_mtvec: begin
                old_value  = mtvec;
                write_mask = mtvec_mask;
            end
            csr_mscratch: begin
                old_value  = mscratch;
                write_mask = full_mask;
            end
            csr_mepc: begin
                old_value  = mepc;
                write_mask = mepc_mask;
            end
            csr_mcause: begin
                old_value  = mcause;
                write_mask = full_mask;
            end
            csr_mtval: begin
                old_value  = mtval;
                write_mask = full_mask;
            end
            csr_mcycle: begin
                old_value  = mcycle;
                write_mask = full_mask;
            end
            csr_minstret: begin
                old_value  = minstret;
                write_mask = full_mask;
            end
            csr_cycle:    old_value = mcycle;   // user shadows.
            csr_instret:  old_value = minstret;
            csr_mhartid:  old_value = hartid_value;
            default:      implemented = 1'b0;
        endcase
    end

    assign read_only = (addr[11:10] == 2'b11);
    assign addr_ok   = implemented && !(write_req && read_only);

    assign masked_value   = (old_value & ~write_mask) | (new_value & write_mask);
    assign write_mcycle   = commit && (addr == csr_mcycle);
    assign write_minstret = commit && (addr == csr_minstret);

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (commit) begin
            case (csr_addr_e'(addr))
                csr_mstatus:  mstatus  <= masked_value;
                csr_mie:      mie      <= masked_value;
                csr_mtvec:    mtvec    <= masked_value;
                csr_mscratch: mscratch <= masked_value;
                csr_mepc:     mepc     <= masked_value;
                csr_mcause:   mcause   <= masked_value;
                csr_mtval:    mtval    <= masked_value;
                default: ;
            endcase
        end
    end

    // a write wins over the count.
    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= write_mcycle ? masked_value : mcycle + 1'b1;
            if (write_minstret) begin
                minstret <= masked_value;
            end else if (retire) begin
                minstret <= minstret + 1'b1;
            end
        end
    end

    // top must gate commit with legality.
    a_commit_legal: assert property (@(posedge clk) disable iff (reset)
        commit |-> addr_ok);

endmodule

/* source/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  csr_pkg::csr_issue_t   issue,
    output csr_pkg::csr_result_t  result
);
    import csr_pkg::*;

    csr_req_t        req;
    logic [xlen-1:0] old_value;
    logic [xlen-1:0] new_value;
    logic            addr_ok;
    logic            write_req;
    logic            illegal;
    logic            commit;
    logic            retire;

    csr_decoder u_csr_decoder (
        .issue (issue),
        .req   (req)
    );

    csr_file u_csr_file (
        .clk       (clk),
        .reset     (reset),
        .addr      (req.addr),
        .write_req (write_req),
        .commit    (commit),
        .new_value (new_value),
        .retire    (retire),
        .old_value (old_value),
        .addr_ok   (addr_ok)
    );

    csr_alu u_csr_alu (
        .op        (req.op),
        .operand   (req.operand),
        .src_zero  (req.src_zero),
        .old_value (old_value),
        .new_value (new_value),
        .write_req (write_req)
    );

    // read-only writes already folded into addr_ok.
    assign illegal = req.bad_encoding || !addr_ok;
    assign commit  = req.valid && write_req && !illegal;
    assign retire  = req.valid && !illegal;

    always_ff @(posedge clk) begin
        if (reset) begin
            result.done     <= 1'b0;
            result.illegal  <= 1'b0;
            result.rd_write <= 1'b0;
        end else begin
            result.done     <= req.valid;
            result.illegal  <= req.valid && illegal;
            result.rd_write <= retire && (req.rd_addr != '0); // x0 never written.
        end
        result.rd_addr <= req.rd_addr;
        result.rd_data <= old_value; // value before the write.
    end

    // instruction word known when valid.
    a_issue_known: assert property (@(posedge clk) disable iff (reset)
        issue.valid |-> !$isunknown(issue.instr));

endmodule

/* test/csr_unit_tb.sv */
`timescale 1ns/1ps

module csr_unit_tb;
    import csr_pkg::*;

    localparam int reset_cycles  = 8;
    localparam int table_rows    = 30;
    localparam int random_count  = 40;
    localparam int timeout_limit = 4 * (table_rows + random_count) + reset_cycles;

    typedef struct packed {
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic [11:0]     addr;
        logic [4:0]      rs1_field;
        logic [4:0]      rd;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] exp_data;
        logic            exp_illegal;
        logic            check_data;
    } row_t;

    logic        clk;
    logic        reset;
    csr_issue_t  issue;
    csr_result_t result;

    row_t            rows[$];
    logic [31:0]     lfsr_state;
    logic [xlen-1:0] shadow[7];
    int              cycles = 0;
    int              tests;
    int              failures;

    csr_unit u_csr_unit (
        .clk    (clk),
        .reset  (reset),
        .issue  (issue),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] encode_instr(input logic [6:0] opcode,
                                                 input logic [2:0] funct3,
                                                 input logic [11:0] addr,
                                                 input logic [4:0] rs1_field,
                                                 input logic [4:0] rd);
        return {addr, rs1_field, funct3, rd, opcode};
    endfunction

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_step()};
        end
        return bits;
    endfunction

    function automatic csr_funct3_e pick_op(input int sel);
        case (sel)
            0:       return csrrw;
            1:       return csrrs;
            2:       return csrrc;
            3:       return csrrwi;
            4:       return csrrsi;
            default: return csrrci;
        endcase
    endfunction

    function automatic logic [11:0] csr_of_index(input int idx);
        case (idx)
            0:       return csr_mstatus;
            1:       return csr_mie;
            2:       return csr_mtvec;
            3:       return csr_mscratch;
            4:       return csr_mepc;
            5:       return csr_mcause;
            default: return csr_mtval;
        endcase
    endfunction

    function automatic logic [xlen-1:0] mask_of_index(input int idx);
        case (idx)
            0:       return mstatus_mask;
            1:       return mie_mask;
            2:       return mtvec_mask;
            4:       return mepc_mask;
            default: return full_mask;
        endcase
    endfunction

    task automatic add_row(input logic [2:0] funct3, input logic [11:0] addr,
                           input logic [4:0] rs1_field, input logic [4:0] rd,
                           input logic [31:0] rs1_data, input logic [31:0] exp_data,
                           input logic exp_illegal);
        row_t r;
        r = '{opcode_system, funct3, addr, rs1_field, rd, rs1_data, exp_data,
              exp_illegal, !exp_illegal};
        rows.push_back(r);
    endtask

    task automatic build_table();
        // read-modify-write on mscratch.
        add_row(csrrw,  csr_mscratch, 5'd1,  5'd2,  32'hA5A5_0F0F, 32'h0000_0000, 1'b0);
        add_row(csrrs,  csr_mscratch, 5'd3,  5'd4,  32'h0000_F0F0, 32'hA5A5_0F0F, 1'b0);
        add_row(csrrc,  csr_mscratch, 5'd5,  5'd6,  32'hA5A5_0000, 32'hA5A5_FFFF, 1'b0);
        add_row(csrrwi, csr_mscratch, 5'h15, 5'd7,  32'hFFFF_FFFF, 32'h0000_FFFF, 1'b0);
        add_row(csrrsi, csr_mscratch, 5'h0A, 5'd8,  32'h0000_0000, 32'h0000_0015, 1'b0);
        add_row(csrrci, csr_mscratch, 5'h03, 5'd9,  32'h0000_0000, 32'h0000_001F, 1'b0);
        add_row(csrrs,  csr_mscratch, 5'd0,  5'd10, 32'h0000_0000, 32'h0000_001C, 1'b0);
        // zero source leaves it alone.
        add_row(csrrs,  csr_mscratch, 5'd0,  5'd11, 32'hFFFF_FFFF, 32'h0000_001C, 1'b0);
        add_row(csrrc,  csr_mscratch, 5'd0,  5'd0,  32'hFFFF_FFFF, 32'h0000_001C, 1'b0);
        add_row(csrrsi, csr_mscratch, 5'd0,  5'd0,  32'h0000_0000, 32'h0000_001C, 1'b0);
        add_row(csrrci, csr_mscratch, 5'd0,  5'd12, 32'h0000_0000, 32'h0000_001C, 1'b0);
        add_row(csrrs,  csr_mscratch, 5'd0,  5'd13, 32'h0000_0000, 32'h0000_001C, 1'b0);
        // all ones through the masks.
        add_row(csrrw,  csr_mstatus,  5'd1,  5'd1,  32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
        add_row(csrrs,  csr_mstatus,  5'd0,  5'd1,  32'h0000_0000, mstatus_mask,  1'b0);
        add_row(csrrw,  csr_mie,      5'd1,  5'd1,  32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
        add_row(csrrs,  csr_mie,      5'd0,  5'd1,  32'h0000_0000, mie_mask,      1'b0);
        add_row(csrrw,  csr_mtvec,    5'd1,  5'd1,  32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
        add_row(csrrs,  csr_mtvec,    5'd0,  5'd1,  32'h0000_0000, mtvec_mask,    1'b0);
        add_row(csrrw,  csr_mepc,     5'd1,  5'd1,  32'hFFFF_FFFF, 32'h0000_0000, 1'b0);
        add_row(csrrs,  csr_mepc,     5'd0,  5'd1,  32'h0000_0000, mepc_mask,     1'b0);
        add_row(csrrw,  csr_misa,     5'd1,  5'd1,  32'hFFFF_FFFF, misa_value,    1'b0);
        add_row(csrrs,  csr_misa,     5'd0,  5'd1,  32'h0000_0000, misa_value,    1'b0);
        // illegal cases.
        add_row(csrrw,  12'h7C0,      5'd1,  5'd3,  32'h0000_1234, 32'h0000_0000, 1'b1);
        add_row(csrrw,  csr_cycle,    5'd1,  5'd3,  32'h0000_1234, 32'h0000_0000, 1'b1);
        add_row(csrrs,  csr_mhartid,  5'd2,  5'd3,  32'hFFFF_FFFF, 32'h0000_0000, 1'b1);
        add_row(funct3_reserved, csr_mscratch, 5'd1, 5'd3, 32'hFFFF_FFFF, '0, 1'b1);
        add_row(csrrw,  csr_mscratch, 5'd1,  5'd3,  32'h0000_DEAD, 32'h0000_0000, 1'b1);
        rows[rows.size() - 1].opcode = opcode_op;
        add_row(csrrs,  csr_mscratch, 5'd0,  5'd14, 32'h0000_0000, 32'h0000_001C, 1'b0);
        add_row(csrrs,  csr_cycle,    5'd0,  5'd15, 32'h0000_0000, 32'h0000_0000, 1'b0);
        rows[rows.size() - 1].check_data = 1'b0; // counter value, not fixed.
        add_row(csrrs,  csr_mhartid,  5'd0,  5'd16, 32'h0000_0000, 32'h0000_0000, 1'b0);
    endtask

    task automatic issue_and_step(input logic [31:0] instr, input logic [31:0] rs1_data);
        issue.valid    = 1'b1;
        issue.instr    = instr;
        issue.rs1_data = rs1_data;
        @(posedge clk);
        #1;
    endtask

    task automatic idle_step();
        issue.valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string signal, input logic [31:0] expected,
                                   input logic [31:0] actual, inout int errs);
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, signal, expected, actual);
        errs++;
    endtask

    task automatic finish_test(input string tag, input int idx, input int errs);
        tests++;
        if (errs != 0) begin
            failures++;
            $display("%s %0d: failed with %0d errors", tag, idx, errs);
        end else begin
            $display("%s %0d: ok", tag, idx);
        end
    endtask

    task automatic check_result(input string tag, input int idx, input logic [4:0] rd,
                                input logic [31:0] exp_data, input logic exp_illegal,
                                input logic check_data);
        int   errs;
        logic exp_write;
        errs      = 0;
        exp_write = !exp_illegal && (rd != 5'd0);
        if (!result.done) begin
            $display("%s %0d: no done pulse one cycle after the instruction was issued",
                     tag, idx);
            errs++;
        end else begin
            if (result.illegal != exp_illegal) begin
                report_mismatch("result.illegal", 32'(exp_illegal), 32'(result.illegal), errs);
            end
            if (result.rd_write != exp_write) begin
                report_mismatch("result.rd_write", 32'(exp_write), 32'(result.rd_write), errs);
            end
            if (result.rd_addr != rd) begin
                report_mismatch("result.rd_addr", 32'(rd), 32'(result.rd_addr), errs);
            end
            if (check_data && (result.rd_data != exp_data)) begin
                report_mismatch("result.rd_data", exp_data, result.rd_data, errs);
            end
        end
        finish_test(tag, idx, errs);
    endtask

    task automatic check_value(input string tag, input int idx, input string signal,
                               input logic [31:0] expected, input logic [31:0] actual);
        int errs;
        errs = 0;
        if (actual != expected) begin
            report_mismatch(signal, expected, actual, errs);
        end
        finish_test(tag, idx, errs);
    endtask

    task automatic run_table();
        row_t r;
        if (rows.size() != table_rows) begin
            $display("stimulus table holds %0d rows instead of %0d", rows.size(), table_rows);
            failures++;
        end
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            issue_and_step(encode_instr(r.opcode, r.funct3, r.addr, r.rs1_field, r.rd),
                           r.rs1_data);
            check_result("table", i, r.rd, r.exp_data, r.exp_illegal, r.check_data);
        end
        idle_step();
    endtask

    task automatic run_counters();
        logic [31:0] rd_mcycle;
        logic [31:0] rd_minstret;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] written;
        int          legal;
        int          cw;
        int          cr;
        rd_mcycle   = encode_instr(opcode_system, csrrs, csr_mcycle, 5'd0, 5'd1);
        rd_minstret = encode_instr(opcode_system, csrrs, csr_minstret, 5'd0, 5'd2);

        issue_and_step(rd_mcycle, '0); // back to back.
        check_result("counter", 0, 5'd1, '0, 1'b0, 1'b0);
        first = result.rd_data;
        issue_and_step(rd_mcycle, '0);
        check_result("counter", 1, 5'd1, '0, 1'b0, 1'b0);
        second = result.rd_data;
        check_value("counter", 2, "mcycle delta", 32'd1, second - first);

        issue_and_step(rd_minstret, '0);
        check_result("counter", 3, 5'd2, '0, 1'b0, 1'b0);
        first = result.rd_data;
        legal = 1;
        for (int i = 0; i < 3; i++) begin
            issue_and_step(encode_instr(opcode_system, csrrs, csr_mscratch, 5'd0, 5'd3), '0);
            check_result("counter", 4 + i, 5'd3, 32'h0000_001C, 1'b0, 1'b1);
            legal++;
        end
        issue_and_step(encode_instr(opcode_system, csrrw, csr_instret, 5'd1, 5'd3), 32'h55);
        check_result("counter", 7, 5'd3, '0, 1'b1, 1'b0); // not retired.
        issue_and_step(rd_minstret, '0);
        check_result("counter", 8, 5'd2, '0, 1'b0, 1'b0);
        second = result.rd_data;
        check_value("counter", 9, "minstret delta", 32'(legal), second - first);

        written = 32'h1000_0000;
        cw      = cycles;
        issue_and_step(encode_instr(opcode_system, csrrw, csr_mcycle, 5'd4, 5'd0), written);
        check_result("counter", 10, 5'd0, '0, 1'b0, 1'b0);
        repeat (5) idle_step();
        cr = cycles;
        issue_and_step(rd_mcycle, '0);
        check_result("counter", 11, 5'd1, '0, 1'b0, 1'b0);
        check_value("counter", 12, "mcycle after write", written + 32'(cr - cw - 1),
                    result.rd_data);
        idle_step();
    endtask

    task automatic run_random();
        csr_funct3_e     op;
        int              idx;
        logic [31:0]     bits;
        logic [4:0]      rs1_field;
        logic [4:0]      rd;
        logic [31:0]     data;
        logic [xlen-1:0] operand;
        logic [xlen-1:0] old_value;
        logic [xlen-1:0] new_value;
        logic [xlen-1:0] mask;
        logic            writes;
        // state left behind by the table.
        shadow[0] = mstatus_mask;
        shadow[1] = mie_mask;
        shadow[2] = mtvec_mask;
        shadow[3] = 32'h0000_001C;
        shadow[4] = mepc_mask;
        shadow[5] = '0;
        shadow[6] = '0;
        for (int i = 0; i < random_count; i++) begin
            op        = pick_op(int'(next_bits(3) % 6));
            idx       = int'(next_bits(3) % 7);
            bits      = next_bits(5);
            rs1_field = bits[4:0];
            bits      = next_bits(5);
            rd        = bits[4:0];
            data      = next_bits(32);

            // uimm forms.
            operand   = (op inside {csrrwi, csrrsi, csrrci}) ? {27'b0, rs1_field} : data;
            old_value = shadow[idx];
            mask      = mask_of_index(idx);
            case (op)
                csrrw, csrrwi: begin
                    new_value = operand;
                    writes    = 1'b1;
                end
                csrrs, csrrsi: begin
                    new_value = old_value | operand;
                    writes    = (rs1_field != 5'd0);
                end
                default: begin
                    new_value = old_value & ~operand;
                    writes    = (rs1_field != 5'd0);
                end
            endcase
            if (writes) begin
                shadow[idx] = (old_value & ~mask) | (new_value & mask);
            end

            issue_and_step(encode_instr(opcode_system, op, csr_of_index(idx), rs1_field, rd),
                           data);
            check_result("random", i, rd, old_value, 1'b0, 1'b1);
        end
        idle_step();
    endtask

    initial begin
        reset      = 1'b1;
        issue      = '0;
        lfsr_state = 32'd71537;
        tests      = 0;
        failures   = 0;
        build_table();
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        run_table();
        run_counters();
        run_random();

        $display("%0d tests run, %0d with errors", tests, failures);
        if (failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/csr_pkg.sv
source/csr_decoder.sv
source/csr_alu.sv
source/csr_file.sv
source/csr_unit.sv
test/csr_unit_tb.sv

/* Makefile */
VERILATOR  = verilator
TOP        = csr_unit_tb
RTL_TOP    = csr_unit
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
BUILD_FLAGS = --binary --timing --assert -j 0
LINT_FLAGS  = --lint-only --timing --assert
PASS_MSG   = all tests passed
FAIL_MSG   = tests failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
